// File: Makefile
# Verilator build of the VDP command engine testbench

FLIST = flist.f
TOP   = tb_vdp_command

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f $(FLIST) \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: flist.f
+incdir+verilog
verilog/vdp_vram_pkg.sv
verilog/vdp_cmd_pkg.sv
verilog/cmd_regs.sv
verilog/cmd_logic_op.sv
verilog/cmd_sequencer.sv
verilog/vram_port.sv
verilog/vdp_command.sv
tests/vdp_command_assert.sv
tests/tb_vdp_command.sv

// File: tests/tb_vdp_command.sv
/* Testbench for the VDP command engine with a random latency VRAM model
   Runs HMMV, LMMV, PSET, POINT, SRCH and STOP and compares VRAM with a reference copy */
`timescale 1ns/1ps
`include "vdp_macros.svh"

module tb_vdp_command;

  logic        clk;
  logic        reset;
  logic        reg_wr_req;
  logic        reg_wr_ack;
  logic [3:0]  reg_num;
  logic [7:0]  reg_data;
  logic        vram_rd_req;
  logic        vram_rd_ack;
  logic        vram_wr_req;
  logic        vram_wr_ack;
  logic [7:0]  vram_rd_data;
  logic [16:0] vram_addr;
  logic [7:0]  vram_wr_data;
  logic [7:0]  clr;
  logic        ce;
  logic        bd;
  logic [9:0]  sx_result;

  logic [7:0]  mem [0:131071];
  logic [7:0]  exp_mem [0:131071];
  logic [31:0] lcg_state = 32'h360883b6;
  int          mem_delay = 0;
  int          errors = 0;
  int          checks = 0;
  logic        timed_out = 1'b0;
  logic [31:0] rnd;

  vdp_command dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [16:0] addr_of(input int x, input int y);
    return {y[8:0], x[7:0]};
  endfunction

  // Reference logical operation of GRAPHIC 7 commands
  function automatic logic [7:0] logop_rule(input logic [2:0] op, input logic t,
                                            input logic [7:0] s, input logic [7:0] d);
    logic [7:0] r;
    case (op)
      3'd0: r = s;
      3'd1: r = s & d;
      3'd2: r = s | d;
      3'd3: r = s ^ d;
      3'd4: r = ~s;
      default: r = d;
    endcase
    if (t && s == 8'h00) r = d;
    return r;
  endfunction

  // Memory answers each toggle after 0 to 3 falling edges
  always @(negedge clk) begin
    if (!reset && (vram_rd_req != vram_rd_ack || vram_wr_req != vram_wr_ack)) begin
      if (mem_delay == 0) begin
        if (vram_wr_req != vram_wr_ack) begin
          mem[vram_addr] = vram_wr_data;
          vram_wr_ack = vram_wr_req;
        end else begin
          vram_rd_data = mem[vram_addr];
          vram_rd_ack = vram_rd_req;
        end
        rnd = lcg_next();
        mem_delay = int'(rnd[17:16]);
      end else begin
        mem_delay--;
      end
    end
  end

  task automatic check_val(input string name, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      errors++;
      $display("error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic reg_write(input logic [3:0] num, input logic [7:0] data);
    int n;
    if (timed_out) return;
    reg_num = num;
    reg_data = data;
    reg_wr_req = ~reg_wr_req;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (reg_wr_ack != reg_wr_req && n < 50);
    if (reg_wr_ack != reg_wr_req) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: register write was never acknowledged");
    end
  endtask

  task automatic wait_idle();
    int n;
    if (timed_out) return;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (ce && n < 20000);
    if (ce) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: command never finished, ce still high");
    end
  endtask

  task automatic set_coord(input logic [3:0] num_l, input int value);
    reg_write(num_l, value[7:0]);
    reg_write(num_l + 4'd1, {6'd0, value[9:8]});
  endtask

  task automatic compare_mem();
    if (timed_out) return;
    checks++;
    for (int i = 0; i < 131072; i++) begin
      if (mem[i] !== exp_mem[i]) check_val($sformatf("vram[%05h]", i), exp_mem[i], mem[i]);
    end
  endtask

  // Runs HMMV, LMMV or PSET on a rectangle and checks all of VRAM
  task automatic draw_rect(input int dx, input int dy, input int nx, input int ny,
                           input logic [7:0] colour, input logic [7:0] cmr);
    logic [16:0] a;
    set_coord(`VDP_REG_DX_L, dx);
    set_coord(`VDP_REG_DY_L, dy);
    set_coord(`VDP_REG_NX_L, nx);
    set_coord(`VDP_REG_NY_L, ny);
    reg_write(`VDP_REG_CLR, colour);
    reg_write(`VDP_REG_ARG, 8'h00);
    for (int r = 0; r < ny; r++) begin
      for (int c = 0; c < nx && dx + c < 256; c++) begin
        a = addr_of(dx + c, dy + r);
        exp_mem[a] = (cmr[7:4] == 4'hc) ? colour
                                         : logop_rule(cmr[2:0], cmr[3], colour, exp_mem[a]);
      end
    end
    reg_write(`VDP_REG_CMR, cmr);
    wait_idle();
    compare_mem();
  endtask

  task automatic search(input int sx, input int sy, input logic dix, input logic [7:0] colour);
    int x;
    logic found;
    set_coord(`VDP_REG_SX_L, sx);
    set_coord(`VDP_REG_SY_L, sy);
    reg_write(`VDP_REG_CLR, colour);
    reg_write(`VDP_REG_ARG, {5'd0, dix, 2'd0});
    found = 1'b0;
    x = sx;
    while (!found && x >= 0 && x < 256) begin
      if (exp_mem[addr_of(x, sy)] == colour) found = 1'b1;
      else x = dix ? x - 1 : x + 1;
    end
    reg_write(`VDP_REG_CMR, 8'h60);
    wait_idle();
    check_val("bd", found, bd);
    if (found) check_val("sx_result", x, sx_result);
  endtask

  initial begin
    reset = 1'b1;
    reg_wr_req = 1'b0;
    reg_num = 4'd0;
    reg_data = 8'h00;
    vram_rd_ack = 1'b0;
    vram_wr_ack = 1'b0;
    vram_rd_data = 8'h00;
    for (int i = 0; i < 131072; i++) begin
      rnd = lcg_next();
      mem[i] = rnd[23:16];
      exp_mem[i] = mem[i];
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;

    // State right after reset
    check_val("ce", 0, ce);
    check_val("bd", 0, bd);
    check_val("clr", 0, clr);
    check_val("vram_rd_req", vram_rd_ack, vram_rd_req);
    check_val("vram_wr_req", vram_wr_ack, vram_wr_req);

    // HMMV plain and clipped at the right edge
    draw_rect(10, 5, 4, 3, 8'h5a, 8'hc0);
    draw_rect(250, 20, 10, 1, 8'ha7, 8'hc0);

    // LMMV through every logical operation, then transparent with colour 0
    for (int op = 0; op < 5; op++) begin
      draw_rect(20 + op * 10, 40, 6, 2, 8'h3c, {5'b10000, op[2:0]});
    end
    draw_rect(80, 44, 5, 2, 8'h00, 8'h8b);

    // PSET by OR, then POINT reads the same pixel back
    draw_rect(77, 60, 1, 1, 8'h81, 8'h52);
    set_coord(`VDP_REG_SX_L, 77);
    set_coord(`VDP_REG_SY_L, 60);
    reg_write(`VDP_REG_CMR, 8'h40);
    wait_idle();
    check_val("clr", exp_mem[addr_of(77, 60)], clr);

    // SRCH both ways on a random row, then a row with no match
    search(40, 30, 1'b0, exp_mem[addr_of(100, 30)]);
    search(200, 30, 1'b1, exp_mem[addr_of(100, 30)]);
    draw_rect(0, 31, 256, 1, 8'h11, 8'hc0);
    search(0, 31, 1'b0, 8'h22);

    // STOP aborts a large HMMV
    set_coord(`VDP_REG_DX_L, 0);
    set_coord(`VDP_REG_DY_L, 100);
    set_coord(`VDP_REG_NY_L, 64);
    reg_write(`VDP_REG_CMR, 8'hc0);
    repeat (30) @(negedge clk);
    // Fill still running when STOP arrives
    check_val("ce", 1, ce);
    reg_write(`VDP_REG_CMR, 8'h00);
    wait_idle();
    check_val("vram_rd_req", vram_rd_ack, vram_rd_req);
    check_val("vram_wr_req", vram_wr_ack, vram_wr_req);

    errors += dut0.assert0.failures;
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: tests/vdp_command_assert.sv
/* Concurrent checks on the VDP command engine handshakes
   Bound into every vdp_command instance */
`timescale 1ns/1ps

module vdp_command_assert (
  input logic                     clk,
  input logic                     reset,
  input logic                     reg_wr_req,
  input logic                     reg_wr_ack,
  input logic                     vram_rd_req,
  input logic                     vram_rd_ack,
  input logic                     vram_wr_req,
  input logic                     vram_wr_ack,
  input vdp_vram_pkg::vram_addr_t vram_addr,
  input vdp_vram_pkg::pixel_t     vram_wr_data
);

  logic rd_pend;
  logic wr_pend;
  int   failures = 0;

  assign rd_pend = vram_rd_req != vram_rd_ack;
  assign wr_pend = vram_wr_req != vram_wr_ack;

  // Address and data frozen for the whole request
  addr_stable: assert property (@(posedge clk) disable iff (reset)
    (rd_pend || wr_pend) && $past(rd_pend || wr_pend)
      |-> $stable(vram_addr) && $stable(vram_wr_data))
    else begin
      $error("VRAM address or write data moved while a request was pending");
      failures++;
    end

  // Never a read and a write in flight together
  one_pending: assert property (@(posedge clk) disable iff (reset) !(rd_pend && wr_pend))
    else begin
      $error("VRAM read and write requests pending at the same time");
      failures++;
    end

  // Register write acknowledged one cycle after the request toggle
  ack_latency: assert property (@(posedge clk) disable iff (reset)
    $changed(reg_wr_req) |=> $changed(reg_wr_ack))
    else begin
      $error("register write ack did not follow req after one cycle");
      failures++;
    end

endmodule

bind vdp_command vdp_command_assert assert0 (.*);

// File: verilog/cmd_logic_op.sv
/* Logical operation unit for LMMV and PSET
   Combines the source colour with the destination byte read from VRAM */
`timescale 1ns/1ps

module cmd_logic_op (
  input  vdp_cmd_pkg::logop_t  logop,
  input  logic                 transparent,
  input  vdp_vram_pkg::pixel_t src,
  input  vdp_vram_pkg::pixel_t dest,
  output vdp_vram_pkg::pixel_t result
);

  vdp_vram_pkg::pixel_t op_out;

  always_comb begin
    case (logop)
      vdp_cmd_pkg::LOP_IMP: op_out = src;
      vdp_cmd_pkg::LOP_AND: op_out = src & dest;
      vdp_cmd_pkg::LOP_OR:  op_out = src | dest;
      vdp_cmd_pkg::LOP_XOR: op_out = src ^ dest;
      vdp_cmd_pkg::LOP_NOT: op_out = ~src;
      // Undefined codes leave VRAM as it was
      default:              op_out = dest;
    endcase
  end

  // Transparent variants skip colour 0
  assign result = (transparent && src == '0) ? dest : op_out;

endmodule

// File: verilog/cmd_regs.sv
/* Command register file R32 to R46 with the toggle write handshake
   A write to R46 starts a new command and aborts the running one */
`timescale 1ns/1ps
`include "vdp_macros.svh"

module cmd_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   reg_wr_req,
  input  logic [3:0]             reg_num,
  input  vdp_vram_pkg::pixel_t   reg_data,
  input  logic                   clr_load,
  input  vdp_vram_pkg::pixel_t   clr_value,
  output logic                   reg_wr_ack,
  output logic                   cmd_hold,
  output logic                   cmd_start,
  output vdp_vram_pkg::coord_t   sx,
  output vdp_vram_pkg::coord_t   sy,
  output vdp_vram_pkg::coord_t   dx,
  output vdp_vram_pkg::coord_t   dy,
  output vdp_vram_pkg::coord_t   nx,
  output vdp_vram_pkg::coord_t   ny,
  output vdp_vram_pkg::pixel_t   clr,
  output logic                   eq,
  output logic                   dix,
  output logic                   diy,
  output vdp_cmd_pkg::cmd_code_t cmd,
  output vdp_cmd_pkg::logop_t    logop,
  output logic                   transparent
);

  // R46 as written by the CPU
  vdp_vram_pkg::pixel_t cmr;

  // Write pending while req and ack differ, the sequencer stalls meanwhile
  assign cmd_hold = reg_wr_req != reg_wr_ack;

  // CMR fields
  assign cmd         = vdp_cmd_pkg::cmd_code_t'(cmr[7:4]);
  assign transparent = cmr[3];
  assign logop       = vdp_cmd_pkg::logop_t'(cmr[2:0]);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      cmd_start  <= 1'b0;
      sx         <= '0;
      sy         <= '0;
      dx         <= '0;
      dy         <= '0;
      nx         <= '0;
      ny         <= '0;
      clr        <= '0;
      eq         <= 1'b0;
      dix        <= 1'b0;
      diy        <= 1'b0;
      cmr        <= '0;
    end else if (cmd_hold) begin
      reg_wr_ack <= ~reg_wr_ack;
      // Start stays up across back to back writes so the sequencer sees it
      cmd_start  <= cmd_start || (reg_num == `VDP_REG_CMR);
      case (reg_num)
        // High bytes keep only bits 1 to 0
        `VDP_REG_SX_L: sx[7:0] <= reg_data;
        `VDP_REG_SX_H: sx[9:8] <= reg_data[1:0];
        `VDP_REG_SY_L: sy[7:0] <= reg_data;
        `VDP_REG_SY_H: sy[9:8] <= reg_data[1:0];
        `VDP_REG_DX_L: dx[7:0] <= reg_data;
        `VDP_REG_DX_H: dx[9:8] <= reg_data[1:0];
        `VDP_REG_DY_L: dy[7:0] <= reg_data;
        `VDP_REG_DY_H: dy[9:8] <= reg_data[1:0];
        `VDP_REG_NX_L: nx[7:0] <= reg_data;
        `VDP_REG_NX_H: nx[9:8] <= reg_data[1:0];
        `VDP_REG_NY_L: ny[7:0] <= reg_data;
        `VDP_REG_NY_H: ny[9:8] <= reg_data[1:0];
        `VDP_REG_CLR:  clr     <= reg_data;
        `VDP_REG_ARG: begin
          // MM in bit 0 is not supported
          eq  <= reg_data[1];
          dix <= reg_data[2];
          diy <= reg_data[3];
        end
        `VDP_REG_CMR:  cmr     <= reg_data;
        default: ;
      endcase
    end else begin
      cmd_start <= 1'b0;
      // POINT result lands in CLR when no CPU write competes
      if (clr_load) begin
        clr <= clr_value;
      end
    end
  end

endmodule

// File: verilog/cmd_sequencer.sv
/* Command FSM with the x and y loop counters and the colour search
   Drives single VRAM accesses through the port and tracks the status flags */
`timescale 1ns/1ps
`include "vdp_macros.svh"

module cmd_sequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cmd_hold,
  input  logic                   cmd_start,
  input  vdp_cmd_pkg::cmd_code_t cmd,
  input  vdp_vram_pkg::coord_t   sx,
  input  vdp_vram_pkg::coord_t   sy,
  input  vdp_vram_pkg::coord_t   dx,
  input  vdp_vram_pkg::coord_t   dy,
  input  vdp_vram_pkg::coord_t   nx,
  input  vdp_vram_pkg::coord_t   ny,
  input  vdp_vram_pkg::pixel_t   clr,
  input  logic                   eq,
  input  logic                   dix,
  input  logic                   diy,
  input  logic                   done,
  input  vdp_vram_pkg::pixel_t   rd_data,
  input  vdp_vram_pkg::pixel_t   result,
  output logic                   rd_start,
  output logic                   wr_start,
  output vdp_vram_pkg::coord_t   x,
  output vdp_vram_pkg::coord_t   y,
  output vdp_vram_pkg::pixel_t   wr_data,
  output vdp_vram_pkg::pixel_t   src,
  output logic                   clr_load,
  output vdp_vram_pkg::pixel_t   clr_value,
  output logic                   ce,
  output logic                   bd,
  output vdp_vram_pkg::coord_t   sx_result
);

  vdp_cmd_pkg::seq_state_t state;
  vdp_vram_pkg::coord_t    sx_tmp;
  vdp_vram_pkg::coord_t    dx_tmp;
  vdp_vram_pkg::coord_t    nx_tmp;
  vdp_vram_pkg::coord_t    dy_tmp;
  vdp_vram_pkg::coord_t    ny_tmp;
  vdp_vram_pkg::coord_t    x_step;
  vdp_vram_pkg::coord_t    y_step;
  vdp_vram_pkg::coord_t    sx_next;
  // First pass through CHK_LOOP skips the end test
  logic                    init;
  // One VRAM access outstanding at the port
  logic                    mem_busy;
  logic                    x_end;
  logic                    y_end;
  logic                    srch_hit;

  assign x_step  = dix ? `VDP_STEP_BACK : `VDP_STEP_FWD;
  assign y_step  = diy ? `VDP_STEP_BACK : `VDP_STEP_FWD;
  assign sx_next = sx_tmp + x_step;

  // Row done on count exhausted or right edge crossed
  assign x_end = (nx_tmp == '0) || dx_tmp[`VDP_SCREEN_X_BIT];
  // Last row, or top of VRAM reached going up
  assign y_end = (ny_tmp == vdp_vram_pkg::coord_t'(1)) || (diy && dy_tmp == '0);
  // EQ=0 stops on the colour, EQ=1 stops on anything else
  assign srch_hit  = (rd_data == clr) != eq;
  assign sx_result = sx_tmp;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= vdp_cmd_pkg::IDLE;
      init      <= 1'b0;
      mem_busy  <= 1'b0;
      rd_start  <= 1'b0;
      wr_start  <= 1'b0;
      clr_load  <= 1'b0;
      ce        <= 1'b0;
      bd        <= 1'b0;
      sx_tmp    <= '0;
      dx_tmp    <= '0;
      nx_tmp    <= '0;
      dy_tmp    <= '0;
      ny_tmp    <= '0;
      x         <= '0;
      y         <= '0;
      wr_data   <= '0;
      src       <= '0;
      clr_value <= '0;
    end else begin
      // Pulses and the done tracking run even while a CPU write holds the FSM
      rd_start <= 1'b0;
      wr_start <= 1'b0;
      clr_load <= 1'b0;
      if (done) begin
        mem_busy <= 1'b0;
      end
      if (cmd_hold) begin
        state <= state;
      end else if (cmd_start) begin
        // New command, aborts whatever ran before
        sx_tmp <= sx;
        dx_tmp <= dx;
        nx_tmp <= nx;
        dy_tmp <= dy;
        ny_tmp <= ny;
        src    <= clr;
        bd     <= 1'b0;
        init   <= 1'b1;
        case (cmd)
          vdp_cmd_pkg::CMD_POINT, vdp_cmd_pkg::CMD_PSET, vdp_cmd_pkg::CMD_SRCH,
          vdp_cmd_pkg::CMD_LMMV, vdp_cmd_pkg::CMD_HMMV: begin
            ce    <= 1'b1;
            state <= vdp_cmd_pkg::CHK_LOOP;
          end
          // STOP and unknown codes just wind down
          default: state <= vdp_cmd_pkg::EXEC_END;
        endcase
      end else begin
        case (state)
          vdp_cmd_pkg::CHK_LOOP: begin
            if (!init && x_end && y_end) begin
              state <= vdp_cmd_pkg::EXEC_END;
            end else begin
              case (cmd)
                // HMMV writes CLR straight, no read back
                vdp_cmd_pkg::CMD_HMMV: begin
                  wr_data <= src;
                  state   <= vdp_cmd_pkg::WR_VRAM;
                end
                vdp_cmd_pkg::CMD_LMMV, vdp_cmd_pkg::CMD_PSET: state <= vdp_cmd_pkg::PRE_RD;
                vdp_cmd_pkg::CMD_POINT, vdp_cmd_pkg::CMD_SRCH: state <= vdp_cmd_pkg::RD_VRAM;
                default: state <= vdp_cmd_pkg::EXEC_END;
              endcase
              // Next row
              if (!init && x_end) begin
                dx_tmp <= dx;
                nx_tmp <= nx;
                dy_tmp <= dy_tmp + y_step;
                ny_tmp <= ny_tmp - vdp_vram_pkg::coord_t'(1);
              end
            end
            init <= 1'b0;
          end
          // Source read for POINT and SRCH
          vdp_cmd_pkg::RD_VRAM: begin
            if (!mem_busy) begin
              x        <= sx_tmp;
              y        <= sy;
              rd_start <= 1'b1;
              mem_busy <= 1'b1;
              state    <= vdp_cmd_pkg::WAIT_RD;
            end
          end
          vdp_cmd_pkg::WAIT_RD: begin
            if (!mem_busy) begin
              if (cmd == vdp_cmd_pkg::CMD_POINT) begin
                clr_value <= rd_data;
                clr_load  <= 1'b1;
                state     <= vdp_cmd_pkg::EXEC_END;
              end else begin
                state <= vdp_cmd_pkg::SRCH_CHK;
              end
            end
          end
          vdp_cmd_pkg::SRCH_CHK: begin
            if (srch_hit) begin
              bd    <= 1'b1;
              state <= vdp_cmd_pkg::EXEC_END;
            end else if (sx_next[`VDP_SCREEN_X_BIT]) begin
              state <= vdp_cmd_pkg::EXEC_END;
            end else begin
              sx_tmp <= sx_next;
              state  <= vdp_cmd_pkg::RD_VRAM;
            end
          end
          // Destination read ahead of the logical operation
          vdp_cmd_pkg::PRE_RD: begin
            if (!mem_busy) begin
              x        <= dx_tmp;
              y        <= dy_tmp;
              rd_start <= 1'b1;
              mem_busy <= 1'b1;
              state    <= vdp_cmd_pkg::WAIT_PRE_RD;
            end
          end
          vdp_cmd_pkg::WAIT_PRE_RD: begin
            if (!mem_busy) begin
              wr_data <= result;
              state   <= vdp_cmd_pkg::WR_VRAM;
            end
          end
          vdp_cmd_pkg::WR_VRAM: begin
            if (!mem_busy) begin
              x        <= dx_tmp;
              y        <= dy_tmp;
              wr_start <= 1'b1;
              mem_busy <= 1'b1;
              state    <= vdp_cmd_pkg::WAIT_WR;
            end
          end
          vdp_cmd_pkg::WAIT_WR: begin
            if (!mem_busy) begin
              if (cmd == vdp_cmd_pkg::CMD_PSET) begin
                state <= vdp_cmd_pkg::EXEC_END;
              end else begin
                dx_tmp <= dx_tmp + x_step;
                nx_tmp <= nx_tmp - vdp_vram_pkg::coord_t'(1);
                state  <= vdp_cmd_pkg::CHK_LOOP;
              end
            end
          end
          // ce drops only after an aborted access has drained
          vdp_cmd_pkg::EXEC_END: begin
            if (!mem_busy) begin
              ce    <= 1'b0;
              state <= vdp_cmd_pkg::IDLE;
            end
          end
          default: state <= vdp_cmd_pkg::IDLE;
        endcase
      end
    end
  end

endmodule

// File: verilog/vdp_cmd_pkg.sv
/* Command side types of the VDP command engine
   Command codes, logical operations and the sequencer state encoding */
package vdp_cmd_pkg;

  // Upper nibble of R46, unlisted codes behave as STOP
  typedef enum logic [3:0] {
    CMD_STOP  = 4'b0000,
    CMD_POINT = 4'b0100,
    CMD_PSET  = 4'b0101,
    CMD_SRCH  = 4'b0110,
    CMD_LMMV  = 4'b1000,
    CMD_HMMV  = 4'b1100
  } cmd_code_t;

  // Low three bits of R46
  typedef enum logic [2:0] {
    LOP_IMP = 3'b000,
    LOP_AND = 3'b001,
    LOP_OR  = 3'b010,
    LOP_XOR = 3'b011,
    LOP_NOT = 3'b100
  } logop_t;

  // Sequencer FSM
  typedef enum logic [3:0] {
    IDLE,
    CHK_LOOP,
    RD_VRAM,
    WAIT_RD,
    PRE_RD,
    WAIT_PRE_RD,
    WR_VRAM,
    WAIT_WR,
    SRCH_CHK,
    EXEC_END
  } seq_state_t;

endpackage

// File: verilog/vdp_command.sv
/* Top of the GRAPHIC 7 VDP command engine
   Register file, sequencer, VRAM port and logical operation unit */
`timescale 1ns/1ps

module vdp_command (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     reg_wr_req,
  input  logic [3:0]               reg_num,
  input  vdp_vram_pkg::pixel_t     reg_data,
  input  logic                     vram_rd_ack,
  input  logic                     vram_wr_ack,
  input  vdp_vram_pkg::pixel_t     vram_rd_data,
  output logic                     reg_wr_ack,
  output logic                     vram_rd_req,
  output logic                     vram_wr_req,
  output vdp_vram_pkg::vram_addr_t vram_addr,
  output vdp_vram_pkg::pixel_t     vram_wr_data,
  output vdp_vram_pkg::pixel_t     clr,
  output logic                     ce,
  output logic                     bd,
  output vdp_vram_pkg::coord_t     sx_result
);

  // Register file to sequencer
  logic                   cmd_hold;
  logic                   cmd_start;
  vdp_vram_pkg::coord_t   sx;
  vdp_vram_pkg::coord_t   sy;
  vdp_vram_pkg::coord_t   dx;
  vdp_vram_pkg::coord_t   dy;
  vdp_vram_pkg::coord_t   nx;
  vdp_vram_pkg::coord_t   ny;
  logic                   eq;
  logic                   dix;
  logic                   diy;
  vdp_cmd_pkg::cmd_code_t cmd;
  vdp_cmd_pkg::logop_t    logop;
  logic                   transparent;
  logic                   clr_load;
  vdp_vram_pkg::pixel_t   clr_value;

  // Sequencer to port and logic unit
  logic                   rd_start;
  logic                   wr_start;
  vdp_vram_pkg::coord_t   x;
  vdp_vram_pkg::coord_t   y;
  vdp_vram_pkg::pixel_t   wr_data;
  vdp_vram_pkg::pixel_t   src;
  logic                   done;
  vdp_vram_pkg::pixel_t   rd_data;
  vdp_vram_pkg::pixel_t   result;

  cmd_regs u_regs (.*);

  cmd_sequencer u_seq (.*);

  vram_port u_port (.*);

  // Destination is the byte the port last read
  cmd_logic_op u_logic_op (
    .logop       (logop),
    .transparent (transparent),
    .src         (src),
    .dest        (rd_data),
    .result      (result)
  );

endmodule

// File: verilog/vdp_macros.svh
/* Shared constants of the VDP command engine
   Included by the packages and by RTL that decodes registers or coordinates */
`ifndef VDP_MACROS_SVH
`define VDP_MACROS_SVH

// Data path widths
`define VDP_COORD_W      10
`define VDP_ADDR_W       17
`define VDP_PIXEL_W      8
// Set in x once a GRAPHIC 7 coordinate leaves the 256 pixel row
`define VDP_SCREEN_X_BIT 8
// Coordinate steps of plus and minus one
`define VDP_STEP_FWD     10'h001
`define VDP_STEP_BACK    10'h3ff

// Register numbers as offsets from R32
`define VDP_REG_SX_L     4'd0
`define VDP_REG_SX_H     4'd1
`define VDP_REG_SY_L     4'd2
`define VDP_REG_SY_H     4'd3
`define VDP_REG_DX_L     4'd4
`define VDP_REG_DX_H     4'd5
`define VDP_REG_DY_L     4'd6
`define VDP_REG_DY_H     4'd7
`define VDP_REG_NX_L     4'd8
`define VDP_REG_NX_H     4'd9
`define VDP_REG_NY_L     4'd10
`define VDP_REG_NY_H     4'd11
`define VDP_REG_CLR      4'd12
`define VDP_REG_ARG      4'd13
`define VDP_REG_CMR      4'd14

`endif

// File: verilog/vdp_vram_pkg.sv
/* Memory side types of the VDP command engine
   Coordinates and counts, VRAM byte addresses and pixel bytes */
`include "vdp_macros.svh"

package vdp_vram_pkg;

  // X or y coordinate, also used for the NX and NY counts
  typedef logic [`VDP_COORD_W-1:0] coord_t;

  // Byte address into the 128 KiB VRAM
  typedef logic [`VDP_ADDR_W-1:0] vram_addr_t;

  // One GRAPHIC 7 pixel or data byte
  typedef logic [`VDP_PIXEL_W-1:0] pixel_t;

endpackage

// File: verilog/vram_port.sv
/* VRAM access port of the command engine
   Forms the GRAPHIC 7 byte address and runs the toggle read and write handshakes */
`timescale 1ns/1ps
`include "vdp_macros.svh"

module vram_port (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     rd_start,
  input  logic                     wr_start,
  input  vdp_vram_pkg::coord_t     x,
  input  vdp_vram_pkg::coord_t     y,
  input  vdp_vram_pkg::pixel_t     wr_data,
  input  logic                     vram_rd_ack,
  input  logic                     vram_wr_ack,
  input  vdp_vram_pkg::pixel_t     vram_rd_data,
  output logic                     done,
  output vdp_vram_pkg::pixel_t     rd_data,
  output logic                     vram_rd_req,
  output logic                     vram_wr_req,
  output vdp_vram_pkg::vram_addr_t vram_addr,
  output vdp_vram_pkg::pixel_t     vram_wr_data
);

  logic busy;
  // Outstanding access is a read
  logic rd_op;
  logic matched;

  assign matched = (vram_rd_req == vram_rd_ack) && (vram_wr_req == vram_wr_ack);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy        <= 1'b0;
      rd_op       <= 1'b0;
      done        <= 1'b0;
      vram_rd_req <= 1'b0;
      vram_wr_req <= 1'b0;
    end else begin
      // done follows the cycle in which ack caught up
      done <= busy && matched;
      if (busy && matched) begin
        busy <= 1'b0;
      end
      if (rd_start) begin
        vram_rd_req <= ~vram_rd_ack;
        busy        <= 1'b1;
        rd_op       <= 1'b1;
      end else if (wr_start) begin
        vram_wr_req <= ~vram_wr_ack;
        busy        <= 1'b1;
        rd_op       <= 1'b0;
      end
    end
  end

  // 256 bytes per row, y above x
  always_ff @(posedge clk) begin
    if (rd_start || wr_start) begin
      vram_addr <= {y[`VDP_ADDR_W-`VDP_SCREEN_X_BIT-1:0], x[`VDP_SCREEN_X_BIT-1:0]};
    end
    if (wr_start) begin
      vram_wr_data <= wr_data;
    end
    if (busy && rd_op && matched) begin
      rd_data <= vram_rd_data;
    end
  end

endmodule
